// File: rtl/regfile_pkg.sv
package regfile_pkg;

    localparam int num_regs      = 8;
    localparam int num_sects     = 3;
    localparam int default_tag_w = 7;

    // section positions inside a sect_en_t.
    localparam int sect_l = 0;
    localparam int sect_h = 1;
    localparam int sect_e = 2;

    typedef enum logic [1:0] {
        size_8    = 2'd0,
        size_16   = 2'd1,
        size_32   = 2'd2,
        size_none = 2'd3
    } size_t;

    typedef logic [2:0]           reg_addr_t;
    typedef logic [num_sects-1:0] sect_en_t;  // e, h, l.
    typedef logic [31:0]          word_t;

    // sections covered by an access of the given size and address.
    function automatic sect_en_t sect_cover(input size_t size, input reg_addr_t addr);
        sect_en_t cov;
        cov = '0;
        case (size)
            size_8:  cov[addr[2] ? sect_h : sect_l] = 1'b1;
            size_16: cov = sect_en_t'(3'b011);
            size_32: cov = sect_en_t'(3'b111);
            default: cov = '0;
        endcase
        return cov;
    endfunction

    // byte addresses 4 to 7 map onto the high byte of registers 0 to 3.
    function automatic reg_addr_t sect_reg(input size_t size, input reg_addr_t addr);
        return (size == size_8) ? {1'b0, addr[1:0]} : addr;
    endfunction

endpackage

// File: rtl/gpr_write_decode.sv
`timescale 1ns/100ps

module gpr_write_decode (
    input  logic                                          wr_en,
    input  regfile_pkg::reg_addr_t                        wr_addr,
    input  regfile_pkg::size_t                            wr_size,
    input  regfile_pkg::word_t                            wr_data,
    input  logic                                          dest_en,
    input  regfile_pkg::reg_addr_t                        dest_addr,
    input  regfile_pkg::size_t                            dest_size,
    output regfile_pkg::sect_en_t [regfile_pkg::num_regs-1:0] load_en,
    output regfile_pkg::sect_en_t [regfile_pkg::num_regs-1:0] mark_en,
    output regfile_pkg::word_t                            sect_data
);
    import regfile_pkg::*;

    reg_addr_t wr_reg;
    reg_addr_t dest_reg;
    sect_en_t  wr_cov;
    sect_en_t  dest_cov;
    logic      wr_high_byte;

    // same section rule for the data write and the pending mark.
    assign wr_reg   = sect_reg(wr_size, wr_addr);
    assign wr_cov   = sect_cover(wr_size, wr_addr);
    assign dest_reg = sect_reg(dest_size, dest_addr);
    assign dest_cov = sect_cover(dest_size, dest_addr);

    assign wr_high_byte = (wr_size == size_8) && wr_addr[2];

    // ah, ch, dh, bh take the low byte of the input.
    assign sect_data = {
        wr_data[31:16],
        wr_high_byte ? wr_data[7:0] : wr_data[15:8],
        wr_data[7:0]
    };

    always_comb begin
        for (int r = 0; r < num_regs; r++) begin
            if (wr_en && (wr_reg == reg_addr_t'(r))) begin
                load_en[r] = wr_cov;
            end else begin
                load_en[r] = '0;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < num_regs; r++) begin
            if (dest_en && (dest_reg == reg_addr_t'(r))) begin
                mark_en[r] = dest_cov;
            end else begin
                mark_en[r] = '0;
            end
        end
    end

endmodule

// File: rtl/gpr_bank.sv
`timescale 1ns/100ps

module gpr_bank #(
    parameter int tag_w = regfile_pkg::default_tag_w
) (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  regfile_pkg::sect_en_t [regfile_pkg::num_regs-1:0] load_en,
    input  regfile_pkg::sect_en_t [regfile_pkg::num_regs-1:0] mark_en,
    input  regfile_pkg::word_t                                sect_data,
    input  logic [tag_w-1:0]                                  new_tag,
    input  logic [tag_w-1:0]                                  result_tag,
    input  logic                                              flush,
    output regfile_pkg::word_t    [regfile_pkg::num_regs-1:0] reg_q,
    output regfile_pkg::sect_en_t [regfile_pkg::num_regs-1:0] pend_q,
    output logic [regfile_pkg::num_regs-1:0][regfile_pkg::num_sects-1:0][tag_w-1:0] tag_q
);
    import regfile_pkg::*;

    logic [num_regs-1:0][num_sects-1:0] tag_hit;

    always_comb begin
        for (int r = 0; r < num_regs; r++) begin
            for (int s = 0; s < num_sects; s++) begin
                tag_hit[r][s] = (tag_q[r][s] == result_tag);
            end
        end
    end

    // data sections with their own load enables.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_q <= '0;
        end else begin
            for (int r = 0; r < num_regs; r++) begin
                if (load_en[r][sect_e]) begin
                    reg_q[r][31:16] <= sect_data[31:16];
                end
                if (load_en[r][sect_h]) begin
                    reg_q[r][15:8] <= sect_data[15:8];
                end
                if (load_en[r][sect_l]) begin
                    reg_q[r][7:0] <= sect_data[7:0];
                end
            end
        end
    end

    // stored tag of the producer that will write the section.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_q <= '0;
        end else begin
            for (int r = 0; r < num_regs; r++) begin
                for (int s = 0; s < num_sects; s++) begin
                    if (mark_en[r][s]) begin
                        tag_q[r][s] <= new_tag;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_q <= '0;
        end else begin
            for (int r = 0; r < num_regs; r++) begin
                for (int s = 0; s < num_sects; s++) begin
                    if (mark_en[r][s]) begin
                        pend_q[r][s] <= 1'b1;  // new producer wins over a clear.
                    end else if (flush) begin
                        pend_q[r][s] <= 1'b0;
                    end else if (tag_hit[r][s]) begin
                        pend_q[r][s] <= 1'b0;  // result broadcast arrived.
                    end
                end
            end
        end
    end

endmodule

// File: rtl/gpr_read_format.sv
`timescale 1ns/100ps

module gpr_read_format #(
    parameter int tag_w = regfile_pkg::default_tag_w
) (
    input  regfile_pkg::reg_addr_t                            rd_addr,
    input  regfile_pkg::size_t                                rd_size,
    input  regfile_pkg::word_t    [regfile_pkg::num_regs-1:0] reg_q,
    input  regfile_pkg::sect_en_t [regfile_pkg::num_regs-1:0] pend_q,
    input  logic [regfile_pkg::num_regs-1:0][regfile_pkg::num_sects-1:0][tag_w-1:0] tag_q,
    output regfile_pkg::word_t                                rd_data,
    output logic                                              rd_pending,
    output logic [tag_w-1:0]                                  rd_tag
);
    import regfile_pkg::*;

    reg_addr_t  rd_reg;
    sect_en_t   rd_cov;
    word_t      rd_word;
    logic [7:0] rd_byte;

    assign rd_reg  = sect_reg(rd_size, rd_addr);
    assign rd_cov  = sect_cover(rd_size, rd_addr);
    assign rd_word = reg_q[rd_reg];

    assign rd_byte = rd_addr[2] ? rd_word[15:8] : rd_word[7:0];

    always_comb begin
        case (rd_size)
            size_8:  rd_data = {{24{rd_byte[7]}}, rd_byte};
            size_16: rd_data = {{16{rd_word[15]}}, rd_word[15:0]};
            size_32: rd_data = rd_word;
            default: rd_data = '0;
        endcase
    end

    assign rd_pending = |(pend_q[rd_reg] & rd_cov);

    // lowest covered section supplies the tag.
    always_comb begin
        if (rd_cov[sect_l]) begin
            rd_tag = tag_q[rd_reg][sect_l];
        end else if (rd_cov[sect_h]) begin
            rd_tag = tag_q[rd_reg][sect_h];
        end else begin
            rd_tag = '0;
        end
    end

endmodule

// File: rtl/regfile_top.sv
`timescale 1ns/100ps

module regfile_top #(
    parameter int tag_w = regfile_pkg::default_tag_w
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_en,
    input  regfile_pkg::reg_addr_t wr_addr,
    input  regfile_pkg::size_t     wr_size,
    input  regfile_pkg::word_t     wr_data,
    input  logic                   dest_en,
    input  regfile_pkg::reg_addr_t dest_addr,
    input  regfile_pkg::size_t     dest_size,
    input  logic [tag_w-1:0]       new_tag,
    input  logic [tag_w-1:0]       result_tag,
    input  logic                   flush,
    input  regfile_pkg::reg_addr_t rd_addr,
    input  regfile_pkg::size_t     rd_size,
    output regfile_pkg::word_t     rd_data,
    output logic                   rd_pending,
    output logic [tag_w-1:0]       rd_tag
);
    import regfile_pkg::*;

    sect_en_t [num_regs-1:0] load_en;
    sect_en_t [num_regs-1:0] mark_en;
    word_t                   sect_data;
    word_t    [num_regs-1:0] reg_q;
    sect_en_t [num_regs-1:0] pend_q;
    logic [num_regs-1:0][num_sects-1:0][tag_w-1:0] tag_q;

    gpr_write_decode u_decode (
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_size   (wr_size),
        .wr_data   (wr_data),
        .dest_en   (dest_en),
        .dest_addr (dest_addr),
        .dest_size (dest_size),
        .load_en   (load_en),
        .mark_en   (mark_en),
        .sect_data (sect_data)
    );

    gpr_bank #(.tag_w(tag_w)) u_bank (
        .clk        (clk),
        .arst_n     (arst_n),
        .load_en    (load_en),
        .mark_en    (mark_en),
        .sect_data  (sect_data),
        .new_tag    (new_tag),
        .result_tag (result_tag),
        .flush      (flush),
        .reg_q      (reg_q),
        .pend_q     (pend_q),
        .tag_q      (tag_q)
    );

    gpr_read_format #(.tag_w(tag_w)) u_read (
        .rd_addr    (rd_addr),
        .rd_size    (rd_size),
        .reg_q      (reg_q),
        .pend_q     (pend_q),
        .tag_q      (tag_q),
        .rd_data    (rd_data),
        .rd_pending (rd_pending),
        .rd_tag     (rd_tag)
    );

endmodule

// File: dv/regfile_checker.sv
`timescale 1ns/100ps

module regfile_checker #(
    parameter int tag_w = 7
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   entry_valid,
    input  int                     entry_idx,
    input  logic                   wr_en,
    input  regfile_pkg::reg_addr_t wr_addr,
    input  regfile_pkg::size_t     wr_size,
    input  regfile_pkg::word_t     wr_data,
    input  logic                   dest_en,
    input  regfile_pkg::reg_addr_t dest_addr,
    input  regfile_pkg::size_t     dest_size,
    input  logic [tag_w-1:0]       new_tag,
    input  logic [tag_w-1:0]       result_tag,
    input  logic                   flush,
    input  regfile_pkg::reg_addr_t rd_addr,
    input  regfile_pkg::size_t     rd_size,
    input  regfile_pkg::word_t     rd_data,
    input  logic                   rd_pending,
    input  logic [tag_w-1:0]       rd_tag,
    output int                     err_count,
    output int                     check_count
);
    import regfile_pkg::*;

    word_t            m_data [8];
    logic [2:0]       m_pend [8];  // bit 2 holds e and bit 0 holds l.
    logic [tag_w-1:0] m_tag  [8][3];

    function automatic logic [2:0] covered(input size_t sz, input reg_addr_t a);
        if (sz == size_32) return 3'b111;
        if (sz == size_16) return 3'b011;
        if (sz == size_8) return (a >= 4) ? 3'b010 : 3'b001;
        return 3'b000;
    endfunction

    function automatic int target(input size_t sz, input reg_addr_t a);
        return (sz == size_8 && a >= 4) ? int'(a) - 4 : int'(a);
    endfunction

    function automatic word_t exp_data(input size_t sz, input reg_addr_t a);
        word_t      w;
        logic [7:0] b;
        w = m_data[target(sz, a)];
        b = (a >= 4) ? w[15:8] : w[7:0];
        if (sz == size_8) return {{24{b[7]}}, b};
        if (sz == size_16) return {{16{w[15]}}, w[15:0]};
        if (sz == size_32) return w;
        return '0;
    endfunction

    function automatic logic [tag_w-1:0] exp_tag(input size_t sz, input reg_addr_t a);
        logic [2:0] c;
        int         r;
        c = covered(sz, a);
        r = target(sz, a);
        for (int s = 0; s < 3; s++) begin
            if (c[s]) return m_tag[r][s];  // lowest section first.
        end
        return '0;
    endfunction

    task automatic compare_entry();
        word_t            d;
        logic             p;
        logic [tag_w-1:0] t;
        logic             ok;
        d  = exp_data(rd_size, rd_addr);
        p  = |(m_pend[target(rd_size, rd_addr)] & covered(rd_size, rd_addr));
        t  = exp_tag(rd_size, rd_addr);
        ok = 1'b1;
        if (rd_data !== d) begin
            $display("Mismatch at %0t: entry %0d rd_data %h, expected %h",
                     $time, entry_idx, rd_data, d);
            ok = 1'b0;
        end
        if (rd_pending !== p) begin
            $display("Mismatch at %0t: entry %0d rd_pending %b, expected %b",
                     $time, entry_idx, rd_pending, p);
            ok = 1'b0;
        end
        if (rd_tag !== t) begin
            $display("Mismatch at %0t: entry %0d rd_tag %h, expected %h",
                     $time, entry_idx, rd_tag, t);
            ok = 1'b0;
        end
        if (ok) $display("entry %0d ok at %0t", entry_idx, $time);
        else err_count++;
        check_count++;
    endtask

    task automatic apply_entry();
        logic [2:0] c;
        int         r;
        if (wr_en) begin
            c = covered(wr_size, wr_addr);
            r = target(wr_size, wr_addr);
            if (c[2]) m_data[r][31:16] = wr_data[31:16];
            if (c[1]) m_data[r][15:8] = (wr_size == size_8) ? wr_data[7:0] : wr_data[15:8];
            if (c[0]) m_data[r][7:0] = wr_data[7:0];
        end
        for (int i = 0; i < 8; i++) begin
            for (int s = 0; s < 3; s++) begin
                if (flush || m_tag[i][s] == result_tag) m_pend[i][s] = 1'b0;
            end
        end
        if (dest_en) begin  // a new mark wins over any clear.
            c = covered(dest_size, dest_addr);
            r = target(dest_size, dest_addr);
            for (int s = 0; s < 3; s++) begin
                if (c[s]) begin
                    m_pend[r][s] = 1'b1;
                    m_tag[r][s]  = new_tag;
                end
            end
        end
    endtask

    initial begin
        err_count   = 0;
        check_count = 0;
    end

    // inputs and outputs here still hold their values from before the edge.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                m_data[i] = '0;
                m_pend[i] = '0;
                for (int s = 0; s < 3; s++) m_tag[i][s] = '0;
            end
        end else begin
            if (entry_valid) compare_entry();
            apply_entry();
        end
    end

endmodule

// File: dv/tb_regfile.sv
`timescale 1ns/100ps

module tb_regfile;
    import regfile_pkg::*;

    localparam int tag_w       = 7;
    localparam int max_entries = 96;

    logic             clk;
    logic             arst_n;
    logic             wr_en;
    reg_addr_t        wr_addr;
    size_t            wr_size;
    word_t            wr_data;
    logic             dest_en;
    reg_addr_t        dest_addr;
    size_t            dest_size;
    logic [tag_w-1:0] new_tag;
    logic [tag_w-1:0] result_tag;
    logic             flush;
    reg_addr_t        rd_addr;
    size_t            rd_size;
    word_t            rd_data;
    logic             rd_pending;
    logic [tag_w-1:0] rd_tag;
    logic             entry_valid;
    int               entry_idx;
    int               err_count;
    int               check_count;

    // stimulus table with one column per DUT input.
    logic             t_wr_en [max_entries];
    reg_addr_t        t_wr_addr [max_entries];
    size_t            t_wr_size [max_entries];
    word_t            t_wr_data [max_entries];
    logic             t_dest_en [max_entries];
    reg_addr_t        t_dest_addr [max_entries];
    size_t            t_dest_size [max_entries];
    logic [tag_w-1:0] t_new_tag [max_entries];
    logic [tag_w-1:0] t_result_tag [max_entries];
    logic             t_flush [max_entries];
    reg_addr_t        t_rd_addr [max_entries];
    size_t            t_rd_size [max_entries];
    int               n_entries;
    logic [31:0]      lfsr_q;
    logic             got_edge;

    regfile_top #(.tag_w(tag_w)) UUT (
        .clk(clk), .arst_n(arst_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_size(wr_size),
        .wr_data(wr_data), .dest_en(dest_en), .dest_addr(dest_addr),
        .dest_size(dest_size), .new_tag(new_tag), .result_tag(result_tag),
        .flush(flush), .rd_addr(rd_addr), .rd_size(rd_size), .rd_data(rd_data),
        .rd_pending(rd_pending), .rd_tag(rd_tag)
    );

    regfile_checker #(.tag_w(tag_w)) u_checker (
        .clk(clk), .arst_n(arst_n), .entry_valid(entry_valid), .entry_idx(entry_idx),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_size(wr_size), .wr_data(wr_data),
        .dest_en(dest_en), .dest_addr(dest_addr), .dest_size(dest_size),
        .new_tag(new_tag), .result_tag(result_tag), .flush(flush), .rd_addr(rd_addr),
        .rd_size(rd_size), .rd_data(rd_data), .rd_pending(rd_pending), .rd_tag(rd_tag),
        .err_count(err_count), .check_count(check_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32, 22, 2, 1.
    endfunction

    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic add_entry(input logic we, input reg_addr_t wa, input size_t ws,
                             input word_t wd, input logic de, input reg_addr_t da,
                             input size_t ds, input logic [tag_w-1:0] nt,
                             input logic [tag_w-1:0] rt, input logic fl,
                             input reg_addr_t ra, input size_t rs);
        t_wr_en[n_entries]      = we;
        t_wr_addr[n_entries]    = wa;
        t_wr_size[n_entries]    = ws;
        t_wr_data[n_entries]    = wd;
        t_dest_en[n_entries]    = de;
        t_dest_addr[n_entries]  = da;
        t_dest_size[n_entries]  = ds;
        t_new_tag[n_entries]    = nt;
        t_result_tag[n_entries] = rt;
        t_flush[n_entries]      = fl;
        t_rd_addr[n_entries]    = ra;
        t_rd_size[n_entries]    = rs;
        n_entries++;
    endtask

    task automatic add_read(input reg_addr_t ra, input size_t rs);
        add_entry(0, 0, size_none, 0, 0, 0, size_none, 0, 0, 0, ra, rs);
    endtask

    task automatic add_write(input reg_addr_t wa, input size_t ws, input word_t wd,
                             input reg_addr_t ra, input size_t rs);
        add_entry(1, wa, ws, wd, 0, 0, size_none, 0, 0, 0, ra, rs);
    endtask

    task automatic add_mark(input reg_addr_t da, input size_t ds,
                            input logic [tag_w-1:0] nt, input reg_addr_t ra, input size_t rs);
        add_entry(0, 0, size_none, 0, 1, da, ds, nt, 0, 0, ra, rs);
    endtask

    task automatic build_table();
        word_t v;
        n_entries = 0;
        for (int r = 0; r < 8; r++) add_read(r, size_32);
        for (int r = 0; r < 8; r++) begin
            take_bits(32, v);
            add_write(r, size_32, v, r, size_16);
        end
        for (int r = 0; r < 8; r++) add_read(r, size_32);
        for (int r = 0; r < 8; r++) add_read(r, size_16);
        for (int a = 0; a < 8; a++) begin
            take_bits(8, v);
            add_write(a, size_8, v, a, size_8);
        end
        for (int r = 0; r < 4; r++) add_read(r, size_32);
        for (int a = 0; a < 8; a++) add_read(a, size_8);
        add_mark(2, size_16, 5, 2, size_16);
        add_read(2, size_16);
        add_read(6, size_8);  // dh shares the mark on register 2.
        add_mark(3, size_none, 9, 3, size_32);
        add_read(3, size_32);
        add_mark(5, size_32, 12, 5, size_32);
        add_mark(4, size_8, 20, 0, size_32);
        add_read(4, size_8);
        add_read(0, size_16);
        add_mark(6, size_16, 7, 6, size_16);
        add_entry(0, 0, size_none, 0, 1, 6, size_16, 7, 7, 0, 2, size_16);
        add_entry(0, 0, size_none, 0, 0, 0, size_none, 0, 5, 0, 6, size_16);
        add_read(6, size_16);
        add_read(2, size_16);
        add_read(5, size_32);
        add_read(5, size_none);  // no section covered while register 5 is pending.
        add_read(4, size_8);
        add_entry(0, 0, size_none, 0, 0, 0, size_none, 0, 0, 1, 5, size_32);
        add_read(5, size_32);
        add_read(0, size_16);
        add_read(6, size_16);
        add_read(4, size_8);
        add_read(2, size_8);
    endtask

    task wait_rise();
        got_edge = 1'b0;
        for (int s = 0; s < 6 && !got_edge; s++) begin
            fork
                begin
                    @(posedge clk);
                    got_edge = 1'b1;
                end
                #7.3;
            join_any
            disable fork;
        end
        if (!got_edge) begin
            $display("Timeout: no rising clock edge arrived in time");
            $display("CHECKS FAILED");
            $finish;
        end
    endtask

    initial begin
        int n;
        arst_n      = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_size     = size_none;
        wr_data     = '0;
        dest_en     = 1'b0;
        dest_addr   = '0;
        dest_size   = size_none;
        new_tag     = '0;
        result_tag  = '0;
        flush       = 1'b0;
        rd_addr     = '0;
        rd_size     = size_none;
        entry_valid = 1'b0;
        entry_idx   = 0;
        lfsr_q      = 32'h70c2;
        build_table();
        for (n = 0; n < 3; n++) wait_rise();
        arst_n <= 1'b1;
        n = 0;
        while (arst_n !== 1'b1 && n < 10) begin
            wait_rise();
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            for (int i = 0; i < n_entries; i++) begin
                wait_rise();
                wr_en       <= t_wr_en[i];
                wr_addr     <= t_wr_addr[i];
                wr_size     <= t_wr_size[i];
                wr_data     <= t_wr_data[i];
                dest_en     <= t_dest_en[i];
                dest_addr   <= t_dest_addr[i];
                dest_size   <= t_dest_size[i];
                new_tag     <= t_new_tag[i];
                result_tag  <= t_result_tag[i];
                flush       <= t_flush[i];
                rd_addr     <= t_rd_addr[i];
                rd_size     <= t_rd_size[i];
                entry_valid <= 1'b1;
                entry_idx   <= i;
            end
            wait_rise();
            entry_valid <= 1'b0;
            wait_rise();
            #1;
            $display("%0d entries checked, %0d failed", check_count, err_count);
            if (err_count == 0 && check_count == n_entries) begin
                $display("ALL CHECKS PASSED");
            end else begin
                if (check_count != n_entries) begin
                    $display("only %0d of %0d entries were checked", check_count, n_entries);
                end
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

// File: list.f
rtl/regfile_pkg.sv
rtl/gpr_write_decode.sv
rtl/gpr_bank.sv
rtl/gpr_read_format.sv
rtl/regfile_top.sv
dv/regfile_checker.sv
dv/tb_regfile.sv

// File: Bender.yml
package:
  name: regfile

sources:
  - rtl/regfile_pkg.sv
  - rtl/gpr_write_decode.sv
  - rtl/gpr_bank.sv
  - rtl/gpr_read_format.sv
  - rtl/regfile_top.sv
  - target: test
    files:
      - dv/regfile_checker.sv
      - dv/tb_regfile.sv
